/* Bender.yml */
package:
  name: paged_reader

sources:
  - hdl/paged_pkg.sv
  - hdl/walk_if.sv
  - hdl/page_table.sv
  - hdl/walk_dispatch.sv
  - hdl/page_walker.sv
  - hdl/word_ram.sv
  - hdl/result_drain.sv
  - hdl/uart_tx.sv
  - hdl/paged_reader_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_paged_reader.sv

/* compile.f */
+incdir+sim
hdl/paged_pkg.sv
hdl/walk_if.sv
hdl/page_table.sv
hdl/walk_dispatch.sv
hdl/page_walker.sv
hdl/word_ram.sv
hdl/result_drain.sv
hdl/uart_tx.sv
hdl/paged_reader_top.sv
sim/tb_paged_reader.sv

/* hdl/page_table.sv */
`timescale 1ns/1ns

module page_table import paged_pkg::*; #(
  parameter int N_WALKERS = 4
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  pt_we,
  input  seg_t  pt_seg,
  input  seg_t  pt_next,
  input  page_t pt_tag,
  input  seg_t  rd_seg  [N_WALKERS],
  output seg_t  rd_next [N_WALKERS],
  output page_t rd_tag  [N_WALKERS]
);

  seg_t  next_q [N_SEGS];  // chain pointer, self = end of chain
  page_t tag_q  [N_SEGS];  // logical page held by the segment

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // every segment a one-entry chain, nothing mapped
      for (int i = 0; i < N_SEGS; i++) begin
        next_q[i] <= seg_t'(i);
        tag_q[i]  <= '0;
      end
    end else if (pt_we) begin
      next_q[pt_seg] <= pt_next;
      tag_q[pt_seg]  <= pt_tag;
    end
  end

  // private read port per walker, no arbitration
  for (genvar i = 0; i < N_WALKERS; i++) begin : g_rd
    assign rd_next[i] = next_q[rd_seg[i]];
    assign rd_tag[i]  = tag_q[rd_seg[i]];
  end

endmodule

/* hdl/page_walker.sv */
`timescale 1ns/1ns

module page_walker import paged_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  seg_t   start_seg,
  output seg_t   rd_seg,
  input  seg_t   rd_next,
  input  page_t  rd_tag,
  walk_if.walker walk
);

  walk_state_t state;
  page_t       want;     // page being searched
  ofs_t        ofs_q;
  seg_t        cur;      // segment under test
  addr_t       phys_q;
  logic        fault_q;

  // idle looks at start_seg so its next pointer is ready at start
  assign rd_seg     = (state == walk_idle) ? start_seg : cur;
  assign walk.busy  = (state != walk_idle);
  assign walk.done  = (state == walk_hold);
  assign walk.phys  = phys_q;
  assign walk.fault = fault_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= walk_idle;
      fault_q <= 1'b0;
    end else begin
      case (state)
        walk_idle: if (walk.start) begin
          fault_q <= 1'b0;
          state   <= (walk.page == '0) ? walk_hold : walk_hop;  // page 0 direct
        end
        walk_hop: if (rd_tag == want) begin
          state <= walk_hold;
        end else if (rd_next == cur) begin
          fault_q <= 1'b1;               // end of chain, no match
          state   <= walk_hold;
        end
        walk_hold: if (walk.take) state <= walk_idle;
        default: state <= walk_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == walk_idle && walk.start) begin
      want   <= walk.page;
      ofs_q  <= walk.ofs;
      cur    <= rd_next;                 // first hop
      phys_q <= {start_seg, walk.ofs};
    end else if (state == walk_hop) begin
      cur    <= rd_next;
      phys_q <= {cur, ofs_q};            // only kept once matched
    end
  end

  // acyclic table bounds a walk to 16 hops
  a_walk_bounded : assert property (
    @(posedge clk) disable iff (!arst_n)
    (state == walk_idle && walk.start) |-> ##[1:17] walk.done
  );

endmodule

/* hdl/paged_pkg.sv */
package paged_pkg;

  localparam int SEG_W  = 4;                    // 16 segments
  localparam int OFS_W  = 3;                    // 8 words per page
  localparam int ADDR_W = SEG_W + OFS_W;
  localparam int N_SEGS  = 1 << SEG_W;
  localparam int N_WORDS = 1 << ADDR_W;         // whole physical space

  typedef logic [SEG_W-1:0]  seg_t;             // physical segment index
  typedef logic [SEG_W-1:0]  page_t;            // logical page / tag, 0 = empty
  typedef logic [OFS_W-1:0]  ofs_t;
  typedef logic [ADDR_W-1:0] addr_t;            // {segment or page, offset}
  typedef logic [15:0]       word_t;
  typedef logic [7:0]        byte_t;

  typedef enum logic [1:0] {
    walk_idle,
    walk_hop,                                   // one chain segment per cycle
    walk_hold                                   // result parked until take
  } walk_state_t;

  typedef enum logic [1:0] {
    drain_wait,
    drain_read,
    drain_send_hi,
    drain_send_lo
  } drain_state_t;

  typedef enum logic [1:0] {
    uart_idle,
    uart_start,
    uart_data,
    uart_stop
  } uart_state_t;

endpackage

/* hdl/paged_reader_top.sv */
`timescale 1ns/1ns

module paged_reader_top import paged_pkg::*; #(
  parameter int N_WALKERS   = 4,
  parameter int CLK_PER_BIT = 868
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  rd_strobe,
  input  addr_t rd_addr,       // logical word address
  output logic  busy,
  input  logic  pt_we,
  input  seg_t  pt_seg,
  input  seg_t  pt_next,
  input  page_t pt_tag,
  input  logic  mem_we,
  input  addr_t mem_addr,
  input  word_t mem_wdata,
  input  seg_t  start_seg,     // current process, stable during walks
  output logic  tx,
  output logic  fault
);

  seg_t  pt_rd_seg  [N_WALKERS];
  seg_t  pt_rd_next [N_WALKERS];
  page_t pt_rd_tag  [N_WALKERS];
  addr_t ram_addr;
  word_t ram_data;
  logic  tx_start, tx_busy;
  byte_t tx_byte;

  walk_if walks [N_WALKERS] ();

  page_table #(.N_WALKERS(N_WALKERS)) page_table_i (
    .clk(clk), .arst_n(arst_n),
    .pt_we(pt_we), .pt_seg(pt_seg), .pt_next(pt_next), .pt_tag(pt_tag),
    .rd_seg(pt_rd_seg), .rd_next(pt_rd_next), .rd_tag(pt_rd_tag)
  );

  walk_dispatch #(.N_WALKERS(N_WALKERS)) walk_dispatch_i (
    .clk(clk), .arst_n(arst_n),
    .rd_strobe(rd_strobe), .rd_addr(rd_addr), .busy(busy),
    .walks(walks)
  );

  for (genvar g = 0; g < N_WALKERS; g++) begin : g_walker
    page_walker page_walker_i (
      .clk(clk), .arst_n(arst_n), .start_seg(start_seg),
      .rd_seg(pt_rd_seg[g]), .rd_next(pt_rd_next[g]), .rd_tag(pt_rd_tag[g]),
      .walk(walks[g])
    );
  end

  word_ram word_ram_i (
    .clk(clk), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .rd_addr(ram_addr), .rd_data(ram_data)
  );

  result_drain #(.N_WALKERS(N_WALKERS)) result_drain_i (
    .clk(clk), .arst_n(arst_n), .walks(walks),
    .ram_addr(ram_addr), .ram_data(ram_data), .fault(fault),
    .tx_start(tx_start), .tx_byte(tx_byte), .tx_busy(tx_busy)
  );

  uart_tx #(.CLK_PER_BIT(CLK_PER_BIT)) uart_tx_i (
    .clk(clk), .arst_n(arst_n),
    .tx_start(tx_start), .tx_byte(tx_byte), .tx_busy(tx_busy), .tx(tx)
  );

endmodule

/* hdl/result_drain.sv */
`timescale 1ns/1ns

module result_drain import paged_pkg::*; #(
  parameter int N_WALKERS = 4
) (
  input  logic  clk,
  input  logic  arst_n,
  walk_if.drain walks [N_WALKERS],
  output addr_t ram_addr,
  input  word_t ram_data,
  output logic  fault,
  output logic  tx_start,
  output byte_t tx_byte,
  input  logic  tx_busy
);

  localparam int PTR_W = (N_WALKERS > 1) ? $clog2(N_WALKERS) : 1;

  drain_state_t         state;
  logic [PTR_W-1:0]     ptr, ptr_nxt;   // same order as dispatch
  logic [N_WALKERS-1:0] done_v, fault_v;
  addr_t                phys_v [N_WALKERS];
  word_t                word_q;
  logic                 hit, take, send_lo;

  for (genvar i = 0; i < N_WALKERS; i++) begin : g_slot
    assign done_v[i]      = walks[i].done;
    assign fault_v[i]     = walks[i].fault;
    assign phys_v[i]      = walks[i].phys;
    assign walks[i].take  = take && (ptr == PTR_W'(i));
  end

  assign ptr_nxt  = (ptr == PTR_W'(N_WALKERS - 1)) ? '0 : ptr + 1'b1;
  assign hit      = (state == drain_wait) && done_v[ptr];
  assign fault    = hit && fault_v[ptr];
  assign take     = hit && (fault_v[ptr] || !tx_busy);  // good words wait for uart
  assign ram_addr = phys_v[ptr];        // sampled by ram on the take edge
  assign send_lo  = (state == drain_send_lo) && !tx_busy;
  assign tx_start = (state == drain_send_hi) || send_lo;
  assign tx_byte  = (state == drain_send_hi) ? word_q[15:8] : word_q[7:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= drain_wait;
      ptr   <= '0;
    end else begin
      case (state)
        drain_wait: if (take) begin
          if (fault_v[ptr]) ptr <= ptr_nxt;   // no bytes for a fault
          else state <= drain_read;
        end
        drain_read:    state <= drain_send_hi;
        drain_send_hi: state <= drain_send_lo;
        drain_send_lo: if (send_lo) begin
          state <= drain_wait;
          ptr   <= ptr_nxt;
        end
        default: state <= drain_wait;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == drain_read) word_q <= ram_data;
  end

  a_tx_idle_on_start : assert property (
    @(posedge clk) disable iff (!arst_n) tx_start |-> !tx_busy
  );

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx import paged_pkg::*; #(
  parameter int CLK_PER_BIT = 868      // 100 MHz / 115200
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  tx_start,
  input  byte_t tx_byte,
  output logic  tx_busy,
  output logic  tx
);

  localparam int CNT_W = $clog2(CLK_PER_BIT + 1);

  uart_state_t      state;
  logic [CNT_W-1:0] cnt;       // cycles into current bit
  logic [2:0]       bit_idx;
  byte_t            sh;        // lsb goes out next
  logic             bit_end;

  assign bit_end = (cnt == CNT_W'(CLK_PER_BIT - 1));
  assign tx_busy = (state != uart_idle);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= uart_idle;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;         // line idles high
    end else begin
      cnt <= (state == uart_idle || bit_end) ? '0 : cnt + 1'b1;
      case (state)
        uart_idle: if (tx_start) begin
          state <= uart_start;
          tx    <= 1'b0;       // start bit
        end
        uart_start: if (bit_end) begin
          state   <= uart_data;
          bit_idx <= '0;
          tx      <= sh[0];
        end
        uart_data: if (bit_end) begin
          if (bit_idx == 3'd7) begin
            state <= uart_stop;
            tx    <= 1'b1;     // stop bit
          end else begin
            bit_idx <= bit_idx + 1'b1;
            tx      <= sh[1];
          end
        end
        uart_stop: if (bit_end) state <= uart_idle;
        default: state <= uart_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == uart_idle && tx_start) sh <= tx_byte;
    else if (state == uart_data && bit_end) sh <= sh >> 1;
  end

endmodule

/* hdl/walk_dispatch.sv */
`timescale 1ns/1ns

module walk_dispatch import paged_pkg::*; #(
  parameter int N_WALKERS = 4
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     rd_strobe,
  input  addr_t    rd_addr,
  output logic     busy,
  walk_if.dispatch walks [N_WALKERS]
);

  localparam int PTR_W = (N_WALKERS > 1) ? $clog2(N_WALKERS) : 1;

  logic [PTR_W-1:0]     ptr;     // walker in turn
  logic [N_WALKERS-1:0] busy_v;
  logic                 issue;

  assign busy  = busy_v[ptr];
  assign issue = rd_strobe && !busy;

  for (genvar i = 0; i < N_WALKERS; i++) begin : g_slot
    assign busy_v[i]      = walks[i].busy;
    assign walks[i].start = issue && (ptr == PTR_W'(i));
    assign walks[i].page  = rd_addr[OFS_W +: SEG_W];  // upper bits = page
    assign walks[i].ofs   = rd_addr[OFS_W-1:0];
  end

  // round robin, same order the drain follows
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr <= '0;
    end else if (issue) begin
      ptr <= (ptr == PTR_W'(N_WALKERS - 1)) ? '0 : ptr + 1'b1;
    end
  end

  // requester must honour busy
  a_no_strobe_busy : assert property (
    @(posedge clk) disable iff (!arst_n) rd_strobe |-> !busy
  );

endmodule

/* hdl/walk_if.sv */
`timescale 1ns/1ns

// one walk slot, dispatch -> walker -> drain
interface walk_if import paged_pkg::*; ();

  logic  start;   // one cycle, only while !busy
  page_t page;
  ofs_t  ofs;
  logic  busy;    // walker occupied until after take
  logic  done;    // result valid, steady until take
  addr_t phys;
  logic  fault;   // unmapped page, valid with done
  logic  take;    // one cycle, only while done

  modport dispatch (output start, page, ofs, input busy);

  modport walker (
    input  start, page, ofs, take,
    output busy, done, phys, fault
  );

  modport drain (output take, input done, phys, fault);

endinterface

/* hdl/word_ram.sv */
`timescale 1ns/1ns

module word_ram import paged_pkg::*; (
  input  logic  clk,
  input  logic  mem_we,
  input  addr_t mem_addr,     // physical
  input  word_t mem_wdata,
  input  addr_t rd_addr,
  output word_t rd_data
);

  word_t mem [N_WORDS];

  always_ff @(posedge clk) begin
    if (mem_we) mem[mem_addr] <= mem_wdata;
  end

  // data one cycle after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* sim/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// mirrors of the DUT table and RAM, kept in step by every write
seg_t  model_next [N_SEGS];
page_t model_tag  [N_SEGS];
word_t model_mem  [N_WORDS];

typedef struct packed {
  logic  is_fault;
  word_t data;
} exp_t;

exp_t exp_q [$];   // oldest request at the front

// table after reset: every segment ends its own chain, nothing mapped
task automatic model_reset();
  for (int i = 0; i < N_SEGS; i++) begin
    model_next[i] = seg_t'(i);
    model_tag[i]  = '0;
  end
endtask

// expected outcome of one logical read for the given process
function automatic exp_t translate(page_t page, ofs_t ofs, seg_t start);
  exp_t e;
  seg_t s;
  e.is_fault = 1'b0;
  e.data     = '0;
  if (page == '0) begin
    e.data = model_mem[{start, ofs}];  // page 0 is the start segment
    return e;
  end
  s = model_next[start];               // search begins one past start
  for (int hop = 0; hop < N_SEGS; hop++) begin
    if (model_tag[s] == page) begin
      e.data = model_mem[{s, ofs}];
      return e;
    end
    if (model_next[s] == s) break;     // chain end, no match
    s = model_next[s];
  end
  e.is_fault = 1'b1;
  return e;
endfunction

`endif

/* sim/tb_paged_reader.sv */
`timescale 1ns/1ns

module tb_paged_reader import paged_pkg::*; ();

  localparam int CLK_PER_BIT = 4;
  localparam int CLK_NS      = 4;
  localparam int BIT_NS      = CLK_PER_BIT * CLK_NS;
  localparam int FRAME_CYC   = 10 * CLK_PER_BIT;
  localparam int SWEEPS      = 2;
  localparam int BURSTS      = 4;
  localparam int BURST_LEN   = 24;
  localparam int N_REQ       = SWEEPS * N_SEGS + BURSTS * BURST_LEN;
  // reset and loads and the idle tail of each phase
  localparam int SETUP_CYC   = 8 + 2 * N_WORDS + 4 * N_SEGS + 2 * FRAME_CYC * (SWEEPS + BURSTS);
  localparam int MAX_CYC     = N_REQ * 2 * FRAME_CYC + SETUP_CYC + 2000;

  logic  clk, arst_n, rd_strobe, busy, pt_we, mem_we, tx, fault;
  addr_t rd_addr, mem_addr;
  seg_t  pt_seg, pt_next, start_seg;
  page_t pt_tag;
  word_t mem_wdata;

  seg_t  proc_start [4];   // first segment of each process chain
  word_t word_exp;         // word whose frames are on the line
  logic  word_open;
  int    cycle_cnt, n_words, n_faults;

`include "tb_model.svh"

  paged_reader_top #(.CLK_PER_BIT(CLK_PER_BIT)) paged_reader_top_i (
    .clk(clk), .arst_n(arst_n),
    .rd_strobe(rd_strobe), .rd_addr(rd_addr), .busy(busy),
    .pt_we(pt_we), .pt_seg(pt_seg), .pt_next(pt_next), .pt_tag(pt_tag),
    .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .start_seg(start_seg), .tx(tx), .fault(fault)
  );

  always #(CLK_NS / 2) clk = ~clk;

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(string msg);
    $display("[FAIL] t=%0t %s", $time, msg);
    abort_run();
  endtask

  task automatic report_error(string msg);
    $display("%s (at %0t ns)", msg, $time);
    abort_run();
  endtask

  task automatic check_word(word_t got);
    if (got !== word_exp) begin
      report_mismatch($sformatf("uart word %h, expected %h", got, word_exp));
    end
    word_open = 1'b0;
    n_words++;
  endtask

  task automatic check_fault();
    exp_t e;
    if (exp_q.size() == 0) report_error("fault pulse with no request outstanding");
    e = exp_q.pop_front();
    if (!e.is_fault) report_mismatch($sformatf("fault pulse, expected word %h", e.data));
    n_faults++;
  endtask

  // idle levels with nothing in flight
  task automatic expect_idle();
    if (busy !== 1'b0 || fault !== 1'b0 || tx !== 1'b1) begin
      report_mismatch($sformatf("busy %b fault %b tx %b, expected idle 0 0 1",
                                busy, fault, tx));
    end
  endtask

  // claim the oldest result as its high byte starts
  task automatic open_word();
    exp_t e;
    if (exp_q.size() == 0) report_error("uart frame with no request outstanding");
    e = exp_q.pop_front();
    if (e.is_fault) report_mismatch("uart bytes sent where a fault was expected");
    word_exp  = e.data;
    word_open = 1'b1;
  endtask

  task automatic receive_byte(output byte_t b, input logic first);
    @(negedge tx);
    if (first) open_word();
    #(BIT_NS / 2);                    // middle of start bit
    if (tx !== 1'b0) report_error("uart start bit did not last half a bit");
    for (int i = 0; i < 8; i++) begin
      #(BIT_NS);
      b[i] = tx;                      // lsb first
    end
    #(BIT_NS);
    if (tx !== 1'b1) report_error("uart stop bit missing");
  endtask

  task automatic load_table_entry(seg_t seg, seg_t nxt, page_t tag);
    pt_we   = 1'b1;
    pt_seg  = seg;
    pt_next = nxt;
    pt_tag  = tag;
    model_next[seg] = nxt;
    model_tag[seg]  = tag;
    @(negedge clk);
    pt_we = 1'b0;
  endtask

  task automatic store_word(addr_t addr, word_t data);
    mem_we    = 1'b1;
    mem_addr  = addr;
    mem_wdata = data;
    model_mem[addr] = data;
    @(negedge clk);
    mem_we = 1'b0;
  endtask

  task automatic fill_ram();
    for (int a = 0; a < N_WORDS; a++) store_word(addr_t'(a), word_t'($urandom));
  endtask

  task automatic scatter_words(int n);
    for (int i = 0; i < n; i++) begin
      store_word(addr_t'($urandom_range(0, N_WORDS - 1)), word_t'($urandom));
    end
  endtask

  // shuffled segments cut into n_proc acyclic chains with unique tags per chain
  task automatic build_chains(int n_proc);
    seg_t  perm [N_SEGS];
    page_t tags [N_SEGS - 1];
    seg_t  tmp_s, seg, nxt;
    page_t tmp_p;
    int    j, len, base;
    for (int i = 0; i < N_SEGS; i++) perm[i] = seg_t'(i);
    for (int i = N_SEGS - 1; i > 0; i--) begin
      j       = $urandom_range(0, i);
      tmp_s   = perm[i];
      perm[i] = perm[j];
      perm[j] = tmp_s;
    end
    base = 0;
    for (int p = 0; p < n_proc; p++) begin
      len = (p == n_proc - 1) ? N_SEGS - base : N_SEGS / n_proc;
      for (int i = 0; i < N_SEGS - 1; i++) tags[i] = page_t'(i + 1);
      for (int i = N_SEGS - 2; i > 0; i--) begin
        j       = $urandom_range(0, i);
        tmp_p   = tags[i];
        tags[i] = tags[j];
        tags[j] = tmp_p;
      end
      proc_start[p] = perm[base];
      for (int k = 0; k < len; k++) begin
        seg = perm[base + k];
        nxt = (k == len - 1) ? seg : perm[base + k + 1];   // last points to itself
        load_table_entry(seg, nxt, (k == 0) ? page_t'(0) : tags[k - 1]);
      end
      base += len;
    end
  endtask

  task automatic issue_read(page_t page, ofs_t ofs);
    while (busy) @(negedge clk);      // walker in turn still held
    exp_q.push_back(translate(page, ofs, start_seg));
    rd_strobe = 1'b1;
    rd_addr   = {page, ofs};
    @(negedge clk);
    rd_strobe = 1'b0;
  endtask

  task automatic sweep_pages();
    for (int p = 0; p < N_SEGS; p++) issue_read(page_t'(p), ofs_t'($urandom));
  endtask

  task automatic random_burst(int n);
    for (int i = 0; i < n; i++) begin
      if ($urandom_range(0, 3) == 0) repeat ($urandom_range(1, 6)) @(negedge clk);
      issue_read(page_t'($urandom), ofs_t'($urandom));
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0 || word_open) @(negedge clk);
    repeat (FRAME_CYC) @(negedge clk);   // let the last stop bit finish
    expect_idle();
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYC) begin
      report_error($sformatf("timeout after %0d cycles, results still pending", MAX_CYC));
    end
  end

  always @(negedge clk) begin
    if (arst_n && fault) check_fault();
  end

  // uart decoder rebuilds each word high byte first
  initial begin
    byte_t hi, lo;
    word_open = 1'b0;
    @(posedge arst_n);
    forever begin
      receive_byte(hi, 1'b1);
      receive_byte(lo, 1'b0);
      check_word({hi, lo});
    end
  end

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    rd_strobe = 1'b0;
    rd_addr   = '0;
    pt_we     = 1'b0;
    pt_seg    = '0;
    pt_next   = '0;
    pt_tag    = '0;
    mem_we    = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    start_seg = '0;
    cycle_cnt = 0;
    n_words   = 0;
    n_faults  = 0;
    void'($urandom(32'h80d7cf41));
    model_reset();
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    expect_idle();
    fill_ram();
    build_chains(2);                   // two long chains for deep hops
    start_seg = proc_start[0];
    sweep_pages();                     // page 0 and every tag and miss
    wait_drained();
    random_burst(BURST_LEN);
    wait_drained();
    scatter_words(N_WORDS / 4);        // new data under old mappings
    build_chains(4);
    start_seg = proc_start[1];
    random_burst(BURST_LEN);
    wait_drained();
    start_seg = proc_start[3];         // other process on the same table
    random_burst(BURST_LEN);
    wait_drained();
    build_chains(3);
    start_seg = proc_start[2];
    random_burst(BURST_LEN);
    wait_drained();
    start_seg = proc_start[0];
    sweep_pages();
    wait_drained();
    $display("checked %0d words and %0d faults", n_words, n_faults);
    $display("Regression passed");
    $finish;
  end

endmodule
